/* src/icache_tag_pkg.sv */
// Instruction cache tag lookup package
// Sizes and vector types shared by the tag store, banks and hit checker

`default_nettype none

package icache_tag_pkg;

    // Tag width per line
    localparam int TAG_W = 8;

    // Line index width for 512 lines
    localparam int INDEX_W = 9;

    // Row address inside one even or odd bank
    localparam int BANK_ADR_W = 8;

    // Fetch address is tag, index and byte offset
    localparam int ADDR_W = 19;

    // Direct-mapped lines of 4 bytes
    localparam int NUM_LINES = 512;

    // Stored line tag
    typedef logic [TAG_W-1:0] tag_t;

    // Line index into the valid array
    typedef logic [INDEX_W-1:0] index_t;

    // Row within a single tag bank
    typedef logic [BANK_ADR_W-1:0] bank_adr_t;

    // Valid bit on top of the tag
    typedef logic [TAG_W:0] entry_t;

    // Fetch or refill byte address
    typedef logic [ADDR_W-1:0] fetch_addr_t;

endpackage

`default_nettype wire

/* src/tag_bank.sv */
// Tag bank of 256 rows by 8 bits
// Synchronous write, asynchronous read on the same row address

`timescale 1ns/1ps
`default_nettype none

module tag_bank (
    input  logic                    clk_i,
    input  logic                    we_i,
    input  icache_tag_pkg::bank_adr_t adr_i,
    input  icache_tag_pkg::tag_t      wdata_i,
    output icache_tag_pkg::tag_t      rdata_o
);
    import icache_tag_pkg::*;

    // Number of rows in one bank
    localparam int ROWS = 2 ** BANK_ADR_W;

    // Tag storage
    tag_t mem [0:ROWS-1];

    // Write on the rising edge when enabled
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[adr_i] <= wdata_i;
        end
    end

    // Combinational read of the addressed row
    assign rdata_o = mem[adr_i];

endmodule

`default_nettype wire

/* src/valid_tag_store.sv */
// Valid bit array with even/odd tag bank steering
// One write port and two read ports mapped onto two external tag banks

`timescale 1ns/1ps
`default_nettype none

module valid_tag_store (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Write port
    input  logic                      wen_i,
    input  icache_tag_pkg::index_t    wadr_i,
    input  icache_tag_pkg::tag_t      wdata_i,
    // Read port 0
    input  icache_tag_pkg::index_t    radr0_i,
    output icache_tag_pkg::entry_t    data0_o,
    // Read port 1
    input  icache_tag_pkg::index_t    radr1_i,
    output icache_tag_pkg::entry_t    data1_o,
    // Even tag bank
    output logic                      we0_o,
    output icache_tag_pkg::bank_adr_t adr0_o,
    output icache_tag_pkg::tag_t      wd0_o,
    input  icache_tag_pkg::tag_t      datao0_i,
    // Odd tag bank
    output logic                      we1_o,
    output icache_tag_pkg::bank_adr_t adr1_o,
    output icache_tag_pkg::tag_t      wd1_o,
    input  icache_tag_pkg::tag_t      datao1_i
);
    import icache_tag_pkg::*;

    // One valid bit per line
    logic [NUM_LINES-1:0] valid_q;

    // Bank rows used for reads
    bank_adr_t rd_row_even;
    bank_adr_t rd_row_odd;

    // Row written by a refill
    bank_adr_t wr_row;

    // Tag picked for each read port
    tag_t tag0;
    tag_t tag1;

    // Valid bits are cleared by reset and set by every refill
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wen_i) begin
            valid_q[wadr_i] <= 1'b1;
        end
    end

    // Write row drops the parity bit
    assign wr_row = wadr_i[INDEX_W-1:1];

    // Port 0 is port 1 or port 1 plus one
    // Odd port 0 means port 1 holds the even index, or both are odd
    assign rd_row_even = radr0_i[0] ? radr1_i[INDEX_W-1:1] : radr0_i[INDEX_W-1:1];
    assign rd_row_odd  = radr0_i[0] ? radr0_i[INDEX_W-1:1] : radr1_i[INDEX_W-1:1];

    // Even bank
    // Write takes the row away from the reads
    assign we0_o  = wen_i & ~wadr_i[0];
    assign adr0_o = wen_i ? wr_row : rd_row_even;
    assign wd0_o  = wdata_i;

    // Odd bank
    assign we1_o  = wen_i & wadr_i[0];
    assign adr1_o = wen_i ? wr_row : rd_row_odd;
    assign wd1_o  = wdata_i;

    // Each port takes the bank of its own parity
    assign tag0 = radr0_i[0] ? datao1_i : datao0_i;
    assign tag1 = radr1_i[0] ? datao1_i : datao0_i;

    // Entries carry the valid bit above the tag
    assign data0_o = {valid_q[radr0_i], tag0};
    assign data1_o = {valid_q[radr1_i], tag1};

endmodule

`default_nettype wire

/* src/fetch_hit_check.sv */
// Fetch hit checker for the instruction cache tags
// Derives both line indices of a fetch and compares stored entries with expected tags

`timescale 1ns/1ps
`default_nettype none

module fetch_hit_check (
    input  icache_tag_pkg::fetch_addr_t fetch_addr_i,
    input  logic                        fill_i,
    // Line indices to the store
    output icache_tag_pkg::index_t      lo_index_o,
    output icache_tag_pkg::index_t      hi_index_o,
    // Entries returned by the store
    input  icache_tag_pkg::entry_t      entry_lo_i,
    input  icache_tag_pkg::entry_t      entry_hi_i,
    // Hit results
    output logic                        hit_lo_o,
    output logic                        hit_hi_o,
    output logic                        hit_o
);
    import icache_tag_pkg::*;

    // Fields of the fetch address
    tag_t   fetch_tag;
    index_t fetch_index;
    logic   crossing;

    // Next line index with carry out of the top
    logic [INDEX_W:0] hi_sum;
    logic             hi_wrap;
    tag_t             hi_tag;

    // Raw compare results before the fill gate
    logic lo_match;
    logic hi_match;

    // Tag in the upper bits, index above the byte offset
    assign fetch_tag   = fetch_addr_i[ADDR_W-1 -: TAG_W];
    assign fetch_index = fetch_addr_i[2 +: INDEX_W];

    // Bit 1 set means the 4-byte fetch spills into the next line
    assign crossing = fetch_addr_i[1];

    // Second line wraps from 511 to 0
    assign hi_sum  = {1'b0, fetch_index} + {{INDEX_W{1'b0}}, crossing};
    assign hi_wrap = hi_sum[INDEX_W];

    // The wrapped line belongs to the next tag
    assign hi_tag = fetch_tag + {{(TAG_W-1){1'b0}}, hi_wrap};

    assign lo_index_o = fetch_index;
    assign hi_index_o = hi_sum[INDEX_W-1:0];

    // Valid and matching tag
    assign lo_match = entry_lo_i[TAG_W] && (entry_lo_i[TAG_W-1:0] == fetch_tag);
    assign hi_match = entry_hi_i[TAG_W] && (entry_hi_i[TAG_W-1:0] == hi_tag);

    // Banks are busy with the refill, so lookups are dropped
    // Non-crossing fetches read the same line twice, hi equals lo
    assign hit_lo_o = lo_match & ~fill_i;
    assign hit_hi_o = hi_match & ~fill_i;
    assign hit_o    = lo_match & hi_match & ~fill_i;

endmodule

`default_nettype wire

/* src/icache_tag_lookup.sv */
// Instruction cache tag lookup top
// Hit checker, valid/tag store and the even and odd tag banks

`timescale 1ns/1ps
`default_nettype none

module icache_tag_lookup (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Fetch lookup
    input  icache_tag_pkg::fetch_addr_t fetch_addr_i,
    // Refill write
    input  logic                        fill_i,
    input  icache_tag_pkg::fetch_addr_t fill_addr_i,
    // Hit results
    output logic                        hit_lo_o,
    output logic                        hit_hi_o,
    output logic                        hit_o
);
    import icache_tag_pkg::*;

    // Checker to store
    index_t lo_index;
    index_t hi_index;
    entry_t entry_lo;
    entry_t entry_hi;

    // Store to even bank
    logic      we_even;
    bank_adr_t adr_even;
    tag_t      wd_even;
    tag_t      rd_even;

    // Store to odd bank
    logic      we_odd;
    bank_adr_t adr_odd;
    tag_t      wd_odd;
    tag_t      rd_odd;

    fetch_hit_check u_hit_check (
        .fetch_addr_i (fetch_addr_i),
        .fill_i       (fill_i),
        .lo_index_o   (lo_index),
        .hi_index_o   (hi_index),
        .entry_lo_i   (entry_lo),
        .entry_hi_i   (entry_hi),
        .hit_lo_o     (hit_lo_o),
        .hit_hi_o     (hit_hi_o),
        .hit_o        (hit_o)
    );

    // Port 0 carries the high line, port 1 the low line
    valid_tag_store u_store (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wen_i    (fill_i),
        .wadr_i   (fill_addr_i[2 +: INDEX_W]),
        .wdata_i  (fill_addr_i[ADDR_W-1 -: TAG_W]),
        .radr0_i  (hi_index),
        .data0_o  (entry_hi),
        .radr1_i  (lo_index),
        .data1_o  (entry_lo),
        .we0_o    (we_even),
        .adr0_o   (adr_even),
        .wd0_o    (wd_even),
        .datao0_i (rd_even),
        .we1_o    (we_odd),
        .adr1_o   (adr_odd),
        .wd1_o    (wd_odd),
        .datao1_i (rd_odd)
    );

    // Even line indices
    tag_bank u_bank_even (
        .clk_i   (clk_i),
        .we_i    (we_even),
        .adr_i   (adr_even),
        .wdata_i (wd_even),
        .rdata_o (rd_even)
    );

    // Odd line indices
    tag_bank u_bank_odd (
        .clk_i   (clk_i),
        .we_i    (we_odd),
        .adr_i   (adr_odd),
        .wdata_i (wd_odd),
        .rdata_o (rd_odd)
    );

endmodule

`default_nettype wire

/* test/valid_tag_store_sva.sv */
// Assertions on the tag bank write steering
// Bound into every valid_tag_store instance

`timescale 1ns/1ps
`default_nettype none

module valid_tag_store_sva (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      wen_i,
    input icache_tag_pkg::index_t    wadr_i,
    input logic                      we0_o,
    input logic                      we1_o,
    input icache_tag_pkg::bank_adr_t adr0_o,
    input icache_tag_pkg::bank_adr_t adr1_o
);
    import icache_tag_pkg::*;

    // Only one bank takes a refill
    a_single_bank_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(we0_o && we1_o)
    ) else $error("both tag bank write enables are high");

    // A bank enable follows the write request
    a_enable_follows_write: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ((we0_o || we1_o) == wen_i)
    ) else $error("bank write enables do not follow wen_i");

    // Write row is the index without its parity bit, on both banks
    a_write_row: assert property (
        @(posedge clk_i) disable iff (rst_i)
        wen_i |-> ((adr0_o == wadr_i[INDEX_W-1:1]) && (adr1_o == wadr_i[INDEX_W-1:1]))
    ) else $error("bank rows differ from the write row during a refill");

endmodule

bind valid_tag_store valid_tag_store_sva u_sva (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .wen_i  (wen_i),
    .wadr_i (wadr_i),
    .we0_o  (we0_o),
    .we1_o  (we1_o),
    .adr0_o (adr0_o),
    .adr1_o (adr1_o)
);

`default_nettype wire

/* test/tb_icache_tag_lookup.sv */
// Testbench for the instruction cache tag lookup
// Table-driven and random refill/lookup sequences checked against a shadow model

`timescale 1ns/1ps
`default_nettype none

module tb_icache_tag_lookup;
    import icache_tag_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int RESET_TIMEOUT = 10;
    localparam int RANDOM_OPS    = 400;
    localparam int MAX_CYCLES    = 2000;

    // One table step: fill flag, address, expected hits
    typedef struct packed {
        logic        fill;
        fetch_addr_t addr;
        logic        hit_lo;
        logic        hit_hi;
        logic        hit;
    } table_row_t;

    logic        clk;
    logic        rst;
    fetch_addr_t fetch_addr;
    logic        fill;
    fetch_addr_t fill_addr;
    logic        hit_lo;
    logic        hit_hi;
    logic        hit;

    int checks;
    int mismatches;
    int timeouts;

    logic [31:0] lfsr_state;

    // Shadow of what the cache should hold per line
    logic shadow_valid [0:NUM_LINES-1];
    tag_t shadow_tag   [0:NUM_LINES-1];

    table_row_t rows [$];

    icache_tag_lookup u_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .fetch_addr_i (fetch_addr),
        .fill_i       (fill),
        .fill_addr_i  (fill_addr),
        .hit_lo_o     (hit_lo),
        .hit_hi_o     (hit_hi),
        .hit_o        (hit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Guard against a run that never ends
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic fetch_addr_t make_addr(input tag_t t, input index_t i,
                                              input logic [1:0] off);
        return {t, i, off};
    endfunction

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Narrow window around the 511 to 0 wrap, four neighbouring tags
    function automatic fetch_addr_t random_addr();
        tag_t        t;
        index_t      i;
        logic [31:0] off;
        t   = 8'hA0 + tag_t'(take_bits(2));
        i   = index_t'(32'd504 + take_bits(4));
        off = take_bits(2);
        return make_addr(t, i, off[1:0]);
    endfunction

    task automatic add_row(input logic f, input fetch_addr_t a, input logic lo,
                           input logic hi, input logic h);
        table_row_t r;
        r.fill   = f;
        r.addr   = a;
        r.hit_lo = lo;
        r.hit_hi = hi;
        r.hit    = h;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Nothing valid right after reset
        add_row(1'b0, make_addr(8'h12, 9'd5, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h00, 9'd0, 2'b10), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'hFF, 9'd511, 2'b10), 1'b0, 1'b0, 1'b0);
        // Single line fill, then hit and a tag miss
        add_row(1'b1, make_addr(8'h12, 9'd5, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h12, 9'd5, 2'b00), 1'b1, 1'b1, 1'b1);
        add_row(1'b0, make_addr(8'h13, 9'd5, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h12, 9'd5, 2'b01), 1'b1, 1'b1, 1'b1);
        // Refill of a valid line reads as a miss in its own cycle
        add_row(1'b1, make_addr(8'h12, 9'd5, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h12, 9'd5, 2'b00), 1'b1, 1'b1, 1'b1);
        // Even to odd crossing
        add_row(1'b1, make_addr(8'h20, 9'd8, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h20, 9'd8, 2'b10), 1'b1, 1'b0, 1'b0);
        add_row(1'b1, make_addr(8'h21, 9'd9, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h20, 9'd8, 2'b10), 1'b1, 1'b0, 1'b0);
        add_row(1'b1, make_addr(8'h20, 9'd9, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h20, 9'd8, 2'b10), 1'b1, 1'b1, 1'b1);
        // Odd to even crossing
        add_row(1'b0, make_addr(8'h12, 9'd5, 2'b10), 1'b1, 1'b0, 1'b0);
        add_row(1'b1, make_addr(8'h12, 9'd6, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h12, 9'd5, 2'b10), 1'b1, 1'b1, 1'b1);
        add_row(1'b0, make_addr(8'h12, 9'd6, 2'b10), 1'b1, 1'b0, 1'b0);
        // Only the second line present
        add_row(1'b1, make_addr(8'h30, 9'd21, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h30, 9'd20, 2'b10), 1'b0, 1'b1, 1'b0);
        // Wrap from 511 to 0 needs the next tag
        add_row(1'b1, make_addr(8'h40, 9'd511, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h40, 9'd511, 2'b10), 1'b1, 1'b0, 1'b0);
        add_row(1'b1, make_addr(8'h40, 9'd0, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h40, 9'd511, 2'b10), 1'b1, 1'b0, 1'b0);
        add_row(1'b1, make_addr(8'h41, 9'd0, 2'b00), 1'b0, 1'b0, 1'b0);
        add_row(1'b0, make_addr(8'h40, 9'd511, 2'b10), 1'b1, 1'b1, 1'b1);
        add_row(1'b0, make_addr(8'h40, 9'd511, 2'b00), 1'b1, 1'b1, 1'b1);
    endtask

    // Expected hits from the shadow model
    task automatic expect_hits(input fetch_addr_t a, input logic fill_now,
                               output logic e_lo, output logic e_hi, output logic e_hit);
        logic [ADDR_W-3:0] line_lo;
        logic [ADDR_W-3:0] line_hi;
        index_t            i_lo;
        index_t            i_hi;
        tag_t              t_lo;
        tag_t              t_hi;
        // Line address is tag over index, so the next line carries into the tag
        line_lo = a[ADDR_W-1:2];
        line_hi = line_lo + {{(ADDR_W-3){1'b0}}, a[1]};
        i_lo = line_lo[INDEX_W-1:0];
        t_lo = line_lo[ADDR_W-3 -: TAG_W];
        i_hi = line_hi[INDEX_W-1:0];
        t_hi = line_hi[ADDR_W-3 -: TAG_W];
        e_lo  = shadow_valid[i_lo] && (shadow_tag[i_lo] == t_lo);
        e_hi  = shadow_valid[i_hi] && (shadow_tag[i_hi] == t_hi);
        e_hit = e_lo && e_hi;
        // Refill cycle blocks every lookup
        if (fill_now) begin
            e_lo  = 1'b0;
            e_hi  = 1'b0;
            e_hit = 1'b0;
        end
    endtask

    task automatic update_shadow(input logic f, input fetch_addr_t fa);
        index_t idx;
        idx = fa[2 +: INDEX_W];
        if (f) begin
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = fa[ADDR_W-1 -: TAG_W];
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_outputs(input logic e_lo, input logic e_hi, input logic e_hit,
                                 input string where);
        check_hit(hit_lo, e_lo, {where, " hit_lo"});
        check_hit(hit_hi, e_hi, {where, " hit_hi"});
        check_hit(hit, e_hit, {where, " hit"});
    endtask

    // Drive on the rising edge, sample half a period later
    task automatic drive_cycle(input logic f, input fetch_addr_t fa, input fetch_addr_t a);
        @(posedge clk);
        fill       <= f;
        fill_addr  <= fa;
        fetch_addr <= a;
        @(negedge clk);
    endtask

    task automatic wait_reset_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while ((rst || hit_lo || hit_hi || hit) && waited < RESET_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rst || hit_lo || hit_hi || hit) begin
            timeouts++;
            $display("hit outputs still not low %0d cycles after reset", RESET_TIMEOUT);
        end
    endtask

    initial begin
        table_row_t  r;
        logic        e_lo;
        logic        e_hi;
        logic        e_hit;
        logic        f;
        fetch_addr_t fa;
        fetch_addr_t a;

        rst        = 1'b1;
        fill       = 1'b0;
        fill_addr  = '0;
        fetch_addr = '0;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        lfsr_state = 32'h4485_3699;
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait_reset_done();

        // Directed rows
        foreach (rows[i]) begin
            r = rows[i];
            drive_cycle(r.fill, r.addr, r.addr);
            check_outputs(r.hit_lo, r.hit_hi, r.hit, $sformatf("table row %0d", i));
            update_shadow(r.fill, r.addr);
        end

        // Random mix, roughly one fill in four
        for (int n = 0; n < RANDOM_OPS; n++) begin
            f  = (take_bits(2) == 32'd0);
            fa = random_addr();
            a  = random_addr();
            drive_cycle(f, fa, a);
            expect_hits(a, f, e_lo, e_hi, e_hit);
            check_outputs(e_lo, e_hi, e_hit, $sformatf("random op %0d addr %h", n, a));
            update_shadow(f, fa);
        end

        @(posedge clk);
        fill <= 1'b0;

        $display("checks %0d mismatches %0d timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/icache_tag_pkg.sv
src/tag_bank.sv
src/valid_tag_store.sv
src/fetch_hit_check.sv
src/icache_tag_lookup.sv
test/valid_tag_store_sva.sv
test/tb_icache_tag_lookup.sv

/* Makefile */
# Verilator build and run for the instruction cache tag lookup testbench

VERILATOR ?= verilator
TOP       ?= tb_icache_tag_lookup
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
